//--- Makefile
# Verilator build for the console controller path

VERILATOR ?= verilator
VFLAGS    ?= --timing --assert
TB_TOP    := pad_top_tb
RTL_TOP   := pad_top
FILELIST  := tb.f
BUILD_DIR := obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) \
		--Mdir $(BUILD_DIR) -o V$(TB_TOP)
	./$(BUILD_DIR)/V$(TB_TOP)

clean:
	rm -rf $(BUILD_DIR)

//--- bench/pad_testdata.txt
# op player ds_byte0 ds_byte1 pad_btn cycles expected   (bytes in hex, cycles decimal)
# M map and shift, F autofire phase at strobe, H hotkey held for cycles (expected 1 or 0)
# single buttons on port 0
M 0 FE FF 00 2 04
M 0 F7 FF 00 2 08
M 0 EF FF 00 2 10
M 0 BF FF 00 2 20
M 0 7F FF 00 2 40
M 0 DF FF 00 2 80
M 0 FF BF 00 2 02
M 0 FF DF 00 2 01
# port 1, combinations and the serial pad
M 1 FF FF A5 2 A5
M 1 5F 9F 00 2 C3
M 1 E7 FF 42 2 5A
M 1 FF FF 00 2 00
M 0 00 00 00 3 FF
# triangle turbo on A
F 0 FF EF 00 1 01
F 0 FF EF 00 4 01
F 0 FF EF 00 5 00
F 0 FF EF 00 8 00
F 0 FF EF 00 9 01
F 0 FF EF 10 13 10
# square turbo on B, both together
F 1 FF 7F 00 3 02
F 1 FF 7F 00 6 00
F 1 FF 7F 00 12 02
F 1 FF 6F 00 10 03
# select and down hotkey
H 0 BE FF 00 5 1
H 1 BE FF 00 5 0
H 0 FF FF 24 3 1
H 0 FE FF 00 3 0

//--- bench/pad_top_tb.sv
/*
 * testbench for the console controller path
 * replays the stimulus records against the DUT and checks the serial
 * console bytes, the autofire phases and the console reset
 */

`timescale 1ns/100ps

module pad_top_tb;

    localparam int CLK_HALF     = 20;
    localparam int DRIVE_DLY    = 2;       // after the rising edge
    localparam int RESET_CYCLES = 10;
    localparam int IDLE_CYCLES  = 3;       // gap between records
    localparam int HOLD_TIMEOUT = 1000;
    localparam int SEED         = 89505;
    localparam int NP           = pad_pkg::NUM_PLAYERS;

    // only these gamepad bits reach the console
    localparam logic [7:0] DS0_USED = 8'((1 << pad_pkg::DS_SELECT) | (1 << pad_pkg::DS_START)
        | (1 << pad_pkg::DS_UP) | (1 << pad_pkg::DS_RIGHT) | (1 << pad_pkg::DS_DOWN)
        | (1 << pad_pkg::DS_LEFT));
    localparam logic [7:0] DS1_USED = 8'((1 << pad_pkg::DS_TRIANGLE)
        | (1 << pad_pkg::DS_CIRCLE) | (1 << pad_pkg::DS_CROSS) | (1 << pad_pkg::DS_SQUARE));

    logic                               clk;
    logic                               sys_resetn;
    logic                               i_joypad_strobe;
    logic [NP-1:0]                      i_joypad_clk;
    logic [NP-1:0][pad_pkg::BTN_W-1:0]  i_ds_byte0;
    logic [NP-1:0][pad_pkg::BTN_W-1:0]  i_ds_byte1;
    logic [NP-1:0][pad_pkg::BTN_W-1:0]  i_pad_btn;
    logic [NP-1:0]                      o_joypad_data;
    logic                               o_nes_reset;

    int                 fd;
    int                 n_items;
    int                 n_records;
    int                 cycles;
    int                 player;
    int                 rec_cnt;
    logic [7:0]         op;
    logic [7:0]         rec_b0;
    logic [7:0]         rec_b1;
    logic [7:0]         rec_pad;
    logic [7:0]         rec_exp;
    logic [8*128-1:0]   line_buf;

    pad_top pad_top_i (
        .clk             (clk),
        .sys_resetn      (sys_resetn),
        .i_joypad_strobe (i_joypad_strobe),
        .i_joypad_clk    (i_joypad_clk),
        .i_ds_byte0      (i_ds_byte0),
        .i_ds_byte1      (i_ds_byte1),
        .i_pad_btn       (i_pad_btn),
        .o_joypad_data   (o_joypad_data),
        .o_nes_reset     (o_nes_reset)
    );

    always #(CLK_HALF) clk = ~clk;

    ////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////
    task automatic report_error(input string msg);
        $display("%s", msg);
        $display("Simulation FAILED");
        $fatal(1);
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #(DRIVE_DLY);
    endtask

    // unused gamepad bits get random levels
    function automatic logic [7:0] with_noise(input logic [7:0] value, input logic [7:0] used);
        logic [7:0] rnd;
        rnd = 8'($urandom);
        return (value & used) | (rnd & ~used);
    endfunction

    task automatic drive_idle();
        for (int p = 0; p < NP; p++) begin
            i_ds_byte0[p] = with_noise(8'hFF, DS0_USED);    // all released
            i_ds_byte1[p] = with_noise(8'hFF, DS1_USED);
            i_pad_btn[p]  = '0;
        end
    endtask

    // one falling edge of a console port clock
    task automatic pulse_port_clk(input int p);
        i_joypad_clk[p] = 1'b0;
        next_cycle();
        i_joypad_clk[p] = 1'b1;
        next_cycle();                  // next bit is out by now
    endtask

    // latch after hold cycles, then shift the byte out of port p
    task automatic read_port(input int p, input int hold, input logic [7:0] expected);
        logic [7:0] got;
        int         other;
        other = (p == 0) ? 1 : 0;
        repeat (hold) next_cycle();
        i_joypad_strobe = 1'b1;
        next_cycle();
        i_joypad_strobe = 1'b0;
        next_cycle();
        got[0] = o_joypad_data[p];     // A comes first
        for (int i = 1; i < pad_pkg::BTN_W + 2; i++) begin
            pulse_port_clk(p);
            if (i < pad_pkg::BTN_W) begin
                got[i] = o_joypad_data[p];
            end else begin
                assert (o_joypad_data[p] == 1'b1) else report_error($sformatf(
                    "Fail: o_joypad_data[%0d] expected %h actual %h", p, 1'b1,
                    o_joypad_data[p]));
            end
            // idle port keeps its latched A bit
            assert (o_joypad_data[other] == 1'b0) else report_error($sformatf(
                "Fail: o_joypad_data[%0d] expected %h actual %h", other, 1'b0,
                o_joypad_data[other]));
        end
        assert (got == expected) else report_error($sformatf(
            "Fail: o_joypad_data[%0d] byte expected %h actual %h", p, expected, got));
    endtask

    task automatic check_hotkey(input int p, input int hold, input logic expected);
        assert (o_nes_reset == 1'b0) else report_error($sformatf(
            "Fail: o_nes_reset before hotkey expected %h actual %h", 1'b0, o_nes_reset));
        for (int i = 0; i < hold; i++) begin
            next_cycle();
            assert (o_nes_reset == expected) else report_error($sformatf(
                "Fail: o_nes_reset player %0d expected %h actual %h", p, expected,
                o_nes_reset));
        end
        drive_idle();
        next_cycle();
        assert (o_nes_reset == 1'b0) else report_error($sformatf(
            "Fail: o_nes_reset after release expected %h actual %h", 1'b0, o_nes_reset));
    endtask

    ////////////////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////////////////
    initial begin
        clk             = 1'b0;
        sys_resetn      = 1'b0;
        i_joypad_strobe = 1'b0;
        i_joypad_clk    = '1;          // console clocks idle high
        void'($urandom(SEED));
        drive_idle();
        n_records = 0;

        fd = $fopen("bench/pad_testdata.txt", "r");
        if (fd == 0) begin
            report_error("could not open the stimulus file bench/pad_testdata.txt");
        end

        repeat (RESET_CYCLES) begin
            next_cycle();
            assert (o_nes_reset == 1'b1) else report_error($sformatf(
                "Fail: o_nes_reset in reset expected %h actual %h", 1'b1, o_nes_reset));
            assert (o_joypad_data == '1) else report_error($sformatf(
                "Fail: o_joypad_data in reset expected %h actual %h", 2'b11, o_joypad_data));
        end
        sys_resetn = 1'b1;

        // startup hold counted from the release
        cycles = 0;
        while (o_nes_reset == 1'b1) begin
            next_cycle();
            cycles++;
            assert (o_joypad_data == '1) else report_error($sformatf(
                "Fail: o_joypad_data in hold expected %h actual %h", 2'b11, o_joypad_data));
            if (cycles > HOLD_TIMEOUT) begin
                report_error("console reset did not end after the startup hold");
            end
        end
        assert (cycles == pad_pkg::STARTUP_HOLD + 1) else report_error($sformatf(
            "Fail: o_nes_reset hold cycles expected %h actual %h",
            pad_pkg::STARTUP_HOLD + 1, cycles));

        while (1) begin
            n_items = $fscanf(fd, " %c", op);
            if (n_items != 1) begin
                break;
            end
            if (op == "#") begin
                void'($fgets(line_buf, fd));    // comment line
                continue;
            end
            n_items = $fscanf(fd, " %d %h %h %h %d %h", player, rec_b0, rec_b1, rec_pad,
                rec_cnt, rec_exp);
            assert (n_items == 6) else report_error("malformed record in the stimulus file");
            assert (player >= 0 && player < NP) else
                report_error("player index out of range in the stimulus file");
            assert (rec_cnt > 0) else report_error("cycle count must be at least one");
            drive_idle();
            i_ds_byte0[player] = with_noise(rec_b0, DS0_USED);
            i_ds_byte1[player] = with_noise(rec_b1, DS1_USED);
            i_pad_btn[player]  = rec_pad;
            case (op)
                "M", "F": read_port(player, rec_cnt, rec_exp);
                "H": check_hotkey(player, rec_cnt, rec_exp[0]);
                default: report_error($sformatf("unknown opcode %c in the stimulus file", op));
            endcase
            n_records++;
            drive_idle();
            repeat (IDLE_CYCLES) next_cycle();
        end
        $fclose(fd);

        if (n_records == 0) begin
            report_error("the stimulus file held no records");
        end else begin
            $display("Simulation PASSED");
            $finish;
        end
    end

endmodule

//--- hdl/autofire.sv
/*
 * autofire
 * while the button is held, the output toggles on and off
 * every AUTOFIRE_HALF cycles, starting with an on phase
 */

`timescale 1ns/100ps

module autofire (
    input  logic clk,
    input  logic i_sys_resetn,
    input  logic i_btn,        // raw press, active high
    output logic o_fire
);

    pad_pkg::af_state_t              state;
    logic [pad_pkg::AF_CNT_W-1:0]    half_cnt;    // cycles left in phase

    ////////////////////////////////////////////////////////////
    // phase FSM
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!i_sys_resetn) begin
            state    <= pad_pkg::AF_IDLE;
            half_cnt <= '0;
            o_fire   <= 1'b0;
        end else if (!i_btn) begin
            state    <= pad_pkg::AF_IDLE;      // release drops out at once
            half_cnt <= '0;
            o_fire   <= 1'b0;
        end else begin
            o_fire <= (state == pad_pkg::AF_ON);   // output trails the state
            case (state)
                pad_pkg::AF_IDLE: begin
                    state    <= pad_pkg::AF_ON;
                    half_cnt <= pad_pkg::AF_RELOAD;
                end
                pad_pkg::AF_ON: begin
                    if (half_cnt == '0) begin
                        state    <= pad_pkg::AF_OFF;
                        half_cnt <= pad_pkg::AF_RELOAD;
                    end else begin
                        half_cnt <= half_cnt - 1'b1;
                    end
                end
                pad_pkg::AF_OFF: begin
                    if (half_cnt == '0) begin
                        state    <= pad_pkg::AF_ON;
                        half_cnt <= pad_pkg::AF_RELOAD;
                    end else begin
                        half_cnt <= half_cnt - 1'b1;
                    end
                end
                default: begin
                    state    <= pad_pkg::AF_IDLE;
                    half_cnt <= '0;
                end
            endcase
        end
    end

    // idle never fires on the following cycle
    a_idle_quiet: assert property (
        @(posedge clk) disable iff (!i_sys_resetn)
        (state == pad_pkg::AF_IDLE) |=> !o_fire
    );

endmodule

//--- hdl/hotkey_reset.sv
/*
 * console reset control
 * holds the console in reset for STARTUP_HOLD cycles after system
 * reset, then resets it while player 1 holds Select and Down
 */

`timescale 1ns/100ps

module hotkey_reset (
    input  logic                        clk,
    input  logic                        i_sys_resetn,
    input  logic [pad_pkg::BTN_W-1:0]   i_buttons,     // player 1 merged byte
    output logic                        o_nes_reset
);

    logic [pad_pkg::HOLD_CNT_W-1:0]  hold_cnt;
    logic                            combo;

    // select + down is the home hotkey
    assign combo = i_buttons[pad_pkg::BTN_SELECT] & i_buttons[pad_pkg::BTN_DOWN];

    ////////////////////////////////////////////////////////////
    // startup hold and hotkey
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!i_sys_resetn) begin
            hold_cnt    <= pad_pkg::HOLD_INIT;
            o_nes_reset <= 1'b1;
        end else if (hold_cnt != '0) begin
            hold_cnt    <= hold_cnt - 1'b1;
            o_nes_reset <= 1'b1;               // still in startup hold
        end else begin
            o_nes_reset <= combo;              // one cycle behind the buttons
        end
    end

    // console stays in reset for the whole hold
    a_hold_reset: assert property (
        @(posedge clk) disable iff (!i_sys_resetn)
        (hold_cnt != '0) |-> o_nes_reset
    );

endmodule

//--- hdl/joypad_port_decoder.sv
/*
 * console joypad port decoder
 * samples the console strobe and per-port clocks, gives the latch
 * level and one-cycle shift pulses on each falling port clock
 */

`timescale 1ns/100ps

module joypad_port_decoder (
    input  logic                             clk,
    input  logic                             i_sys_resetn,
    input  logic                             i_joypad_strobe,
    input  logic [pad_pkg::NUM_PLAYERS-1:0]  i_joypad_clk,
    output logic                             o_load,
    output logic [pad_pkg::NUM_PLAYERS-1:0]  o_shift
);

    logic [pad_pkg::NUM_PLAYERS-1:0] clk_q;    // last sampled port clocks

    ////////////////////////////////////////////////////////////
    // strobe and clock sampling
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!i_sys_resetn) begin
            o_load  <= 1'b0;
            clk_q   <= '0;     // no edge right out of reset
            o_shift <= '0;
        end else begin
            o_load  <= i_joypad_strobe;
            clk_q   <= i_joypad_clk;
            o_shift <= clk_q & ~i_joypad_clk;  // falling edge per port
        end
    end

    ////////////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////////////
    genvar p;
    generate
        for (p = 0; p < pad_pkg::NUM_PLAYERS; p++) begin : g_chk
            // a port clock must rise again before the next shift
            a_shift_single: assert property (
                @(posedge clk) disable iff (!i_sys_resetn)
                o_shift[p] |=> !o_shift[p]
            );
        end
    endgenerate

endmodule

//--- hdl/pad_pkg.sv
/*
 * controller path shared definitions
 * console button bit order, gamepad bit positions, autofire and
 * startup hold timing, and the autofire state encoding
 */

package pad_pkg;

    ////////////////////////////////////////////////////////////
    // port counts and widths
    ////////////////////////////////////////////////////////////
    localparam int NUM_PLAYERS = 2;    // console ports
    localparam int BTN_W       = 8;    // one console button byte

    // console byte order, shifted out lsb first
    localparam int BTN_A      = 0;
    localparam int BTN_B      = 1;
    localparam int BTN_SELECT = 2;
    localparam int BTN_START  = 3;
    localparam int BTN_UP     = 4;
    localparam int BTN_DOWN   = 5;
    localparam int BTN_LEFT   = 6;
    localparam int BTN_RIGHT  = 7;

    // gamepad byte 0, active low
    localparam int DS_SELECT = 0;
    localparam int DS_START  = 3;
    localparam int DS_UP     = 4;
    localparam int DS_RIGHT  = 5;
    localparam int DS_DOWN   = 6;
    localparam int DS_LEFT   = 7;

    // gamepad byte 1, active low
    localparam int DS_TRIANGLE = 4;
    localparam int DS_CIRCLE   = 5;
    localparam int DS_CROSS    = 6;
    localparam int DS_SQUARE   = 7;

    ////////////////////////////////////////////////////////////
    // timing
    ////////////////////////////////////////////////////////////
    localparam int AUTOFIRE_HALF = 4;      // cycles per on or off phase
    localparam int AF_CNT_W      = $clog2(AUTOFIRE_HALF);
    localparam logic [AF_CNT_W-1:0] AF_RELOAD = AF_CNT_W'(AUTOFIRE_HALF - 1);

    localparam int STARTUP_HOLD = 255;     // console reset after power up
    localparam int HOLD_CNT_W   = $clog2(STARTUP_HOLD + 1);
    localparam logic [HOLD_CNT_W-1:0] HOLD_INIT = HOLD_CNT_W'(STARTUP_HOLD);

    typedef enum logic [1:0] {
        AF_IDLE,    // button released
        AF_ON,
        AF_OFF
    } af_state_t;

endpackage

//--- hdl/pad_top.sv
/*
 * console controller path top level
 * port decoder, one channel per player and the console reset block
 */

`timescale 1ns/100ps

module pad_top (
    input  logic                                                clk,
    input  logic                                                sys_resetn,
    input  logic                                                i_joypad_strobe,
    input  logic [pad_pkg::NUM_PLAYERS-1:0]                     i_joypad_clk,
    input  logic [pad_pkg::NUM_PLAYERS-1:0][pad_pkg::BTN_W-1:0] i_ds_byte0,
    input  logic [pad_pkg::NUM_PLAYERS-1:0][pad_pkg::BTN_W-1:0] i_ds_byte1,
    input  logic [pad_pkg::NUM_PLAYERS-1:0][pad_pkg::BTN_W-1:0] i_pad_btn,
    output logic [pad_pkg::NUM_PLAYERS-1:0]                     o_joypad_data,
    output logic                                                o_nes_reset
);

    logic                                                load;
    logic [pad_pkg::NUM_PLAYERS-1:0]                     shift;
    logic [pad_pkg::NUM_PLAYERS-1:0][pad_pkg::BTN_W-1:0] buttons;

    ////////////////////////////////////////////////////////////
    // console port decode
    ////////////////////////////////////////////////////////////
    joypad_port_decoder u_decoder (
        .clk             (clk),
        .i_sys_resetn    (sys_resetn),
        .i_joypad_strobe (i_joypad_strobe),
        .i_joypad_clk    (i_joypad_clk),
        .o_load          (load),
        .o_shift         (shift)
    );

    ////////////////////////////////////////////////////////////
    // player channels
    ////////////////////////////////////////////////////////////
    genvar p;
    generate
        for (p = 0; p < pad_pkg::NUM_PLAYERS; p++) begin : g_player
            player_channel u_channel (
                .clk          (clk),
                .i_sys_resetn (sys_resetn),
                .i_load       (load),          // shared latch
                .i_shift      (shift[p]),
                .i_ds_byte0   (i_ds_byte0[p]),
                .i_ds_byte1   (i_ds_byte1[p]),
                .i_pad_btn    (i_pad_btn[p]),
                .o_buttons    (buttons[p]),
                .o_data       (o_joypad_data[p])
            );
        end
    endgenerate

    // hotkey only on player 1
    hotkey_reset u_hotkey (
        .clk          (clk),
        .i_sys_resetn (sys_resetn),
        .i_buttons    (buttons[0]),
        .o_nes_reset  (o_nes_reset)
    );

endmodule

//--- hdl/player_channel.sv
/*
 * one player channel
 * maps the gamepad bytes to the console button byte, adds autofire
 * on A and B, merges the serial pad, and serializes to the console
 */

`timescale 1ns/100ps

module player_channel (
    input  logic                        clk,
    input  logic                        i_sys_resetn,
    input  logic                        i_load,        // console latch level
    input  logic                        i_shift,       // one pulse per bit
    input  logic [pad_pkg::BTN_W-1:0]   i_ds_byte0,    // active low
    input  logic [pad_pkg::BTN_W-1:0]   i_ds_byte1,    // active low
    input  logic [pad_pkg::BTN_W-1:0]   i_pad_btn,     // active high
    output logic [pad_pkg::BTN_W-1:0]   o_buttons,
    output logic                        o_data
);

    logic                        auto_square;      // turbo B
    logic                        auto_triangle;    // turbo A
    logic [pad_pkg::BTN_W-1:0]   ds_btn;
    logic [pad_pkg::BTN_W-1:0]   shreg;

    ////////////////////////////////////////////////////////////
    // turbo buttons
    ////////////////////////////////////////////////////////////
    autofire u_af_square (
        .clk          (clk),
        .i_sys_resetn (i_sys_resetn),
        .i_btn        (~i_ds_byte1[pad_pkg::DS_SQUARE]),
        .o_fire       (auto_square)
    );

    autofire u_af_triangle (
        .clk          (clk),
        .i_sys_resetn (i_sys_resetn),
        .i_btn        (~i_ds_byte1[pad_pkg::DS_TRIANGLE]),
        .o_fire       (auto_triangle)
    );

    ////////////////////////////////////////////////////////////
    // button mapping
    ////////////////////////////////////////////////////////////
    assign ds_btn[pad_pkg::BTN_RIGHT]  = ~i_ds_byte0[pad_pkg::DS_RIGHT];
    assign ds_btn[pad_pkg::BTN_LEFT]   = ~i_ds_byte0[pad_pkg::DS_LEFT];
    assign ds_btn[pad_pkg::BTN_DOWN]   = ~i_ds_byte0[pad_pkg::DS_DOWN];
    assign ds_btn[pad_pkg::BTN_UP]     = ~i_ds_byte0[pad_pkg::DS_UP];
    assign ds_btn[pad_pkg::BTN_START]  = ~i_ds_byte0[pad_pkg::DS_START];
    assign ds_btn[pad_pkg::BTN_SELECT] = ~i_ds_byte0[pad_pkg::DS_SELECT];

    // cross is B, circle is A
    assign ds_btn[pad_pkg::BTN_B] = ~i_ds_byte1[pad_pkg::DS_CROSS] | auto_square;
    assign ds_btn[pad_pkg::BTN_A] = ~i_ds_byte1[pad_pkg::DS_CIRCLE] | auto_triangle;

    assign o_buttons = ds_btn | i_pad_btn;     // serial pad merged in

    ////////////////////////////////////////////////////////////
    // console shift register
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!i_sys_resetn) begin
            shreg <= '1;                       // idle line reads 1
        end else if (i_load) begin
            shreg <= o_buttons;                // latch wins over shift
        end else if (i_shift) begin
            shreg <= {1'b1, shreg[pad_pkg::BTN_W-1:1]};   // ones fill in
        end
    end

    assign o_data = shreg[0];

    // after a latch the console sees A first
    a_load_a_first: assert property (
        @(posedge clk) disable iff (!i_sys_resetn)
        i_load |=> (o_data == $past(o_buttons[pad_pkg::BTN_A]))
    );

endmodule

//--- tb.f
hdl/pad_pkg.sv
hdl/joypad_port_decoder.sv
hdl/autofire.sv
hdl/player_channel.sv
hdl/hotkey_reset.sv
hdl/pad_top.sv
bench/pad_top_tb.sv
